//--- src/demux_pkg.sv
// port count, field widths and vector types shared by the
// write demux blocks

package demux_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  // number of master ports behind the demux
  localparam int unsigned NumPorts  = 4;
  // width of a master port index
  localparam int unsigned SelWidth  = $clog2(NumPorts);
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // ----------------------------------------------------------------------
  // field types
  // ----------------------------------------------------------------------
  typedef logic [SelWidth-1:0]  sel_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  // burst length minus one, as on the AXI bus
  typedef logic [7:0]           len_t;
  typedef logic [1:0]           resp_t;
  // one bit per master port, for valids and readies
  typedef logic [NumPorts-1:0]  port_vec_t;

endpackage

//--- src/demux_id_table.sv
// per-ID in-flight counters with the master port each ID was sent to

`timescale 1ns/10ps

module demux_id_table #(
  parameter int unsigned MaxTrans = 8,
  parameter int unsigned LookBits = 2
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // lookup of the AW waiting for admission
  input  demux_pkg::id_t  lookup_id_i,
  output demux_pkg::sel_t lookup_sel_o,
  output logic            lookup_busy_o,
  output logic            full_o,
  // push on AW admission
  input  logic            push_i,
  input  demux_pkg::id_t  push_id_i,
  input  demux_pkg::sel_t push_sel_i,
  // pop on slave B transfer
  input  logic            pop_i,
  input  demux_pkg::id_t  pop_id_i
);
  import demux_pkg::*;

  localparam int unsigned NumSlots = 2**LookBits;
  // counter must be able to hold MaxTrans itself
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);

  typedef logic [CntWidth-1:0] cnt_t;
  typedef logic [LookBits-1:0] slot_t;

  cnt_t  cnt_q [NumSlots];
  cnt_t  cnt_d [NumSlots];
  sel_t  sel_q [NumSlots];
  slot_t lookup_slot;
  slot_t push_slot;
  slot_t pop_slot;
  logic  [NumSlots-1:0] cnt_full;

  // only the low ID bits pick a slot, so IDs may share a counter
  assign lookup_slot = lookup_id_i[LookBits-1:0];
  assign push_slot   = push_id_i[LookBits-1:0];
  assign pop_slot    = pop_id_i[LookBits-1:0];

  assign lookup_sel_o  = sel_q[lookup_slot];
  assign lookup_busy_o = (cnt_q[lookup_slot] != '0);
  assign full_o        = |cnt_full;

  // ----------------------------------------------------------------------
  // counter update
  // ----------------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NumSlots; i++) begin
      cnt_d[i]    = cnt_q[i];
      cnt_full[i] = (cnt_q[i] == cnt_t'(MaxTrans));
      // push and pop on the same slot leave the count as it is
      if (push_i && (push_slot == slot_t'(i)) && !(pop_i && (pop_slot == slot_t'(i)))) begin
        cnt_d[i] = cnt_q[i] + cnt_t'(1);
      end else if (pop_i && (pop_slot == slot_t'(i)) && !(push_i && (push_slot == slot_t'(i))))
      begin
        cnt_d[i] = cnt_q[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < NumSlots; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // port recorded by the latest push on each slot
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      sel_q[push_slot] <= push_sel_i;
    end
  end

endmodule

//--- src/aw_route_ctrl.sv
// AW admission checks, valid lock and fan-out of AW to the master ports

`timescale 1ns/10ps

module aw_route_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // slave AW
  input  demux_pkg::id_t       slv_aw_id_i,
  input  demux_pkg::addr_t     slv_aw_addr_i,
  input  demux_pkg::len_t      slv_aw_len_i,
  input  demux_pkg::sel_t      slv_aw_sel_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  // master AW, payload shared by all ports
  output demux_pkg::id_t       mst_aw_id_o,
  output demux_pkg::addr_t     mst_aw_addr_o,
  output demux_pkg::len_t      mst_aw_len_o,
  output demux_pkg::port_vec_t mst_aw_valid_o,
  input  demux_pkg::port_vec_t mst_aw_ready_i,
  // ID table status
  input  demux_pkg::sel_t      lookup_sel_i,
  input  logic                 lookup_busy_i,
  input  logic                 id_full_i,
  // W steering status
  input  logic                 w_busy_i,
  input  logic                 w_full_i,
  input  demux_pkg::sel_t      w_sel_i,
  // admission strobe to ID table and W steering
  output logic                 push_o
);
  import demux_pkg::*;

  logic lock_q;
  logic lock_d;
  logic aw_valid;
  logic aw_ready;
  logic admit_ok;

  // ready of the port the select names
  assign aw_ready = mst_aw_ready_i[slv_aw_sel_i];

  // counters with room, no open W bursts elsewhere, ID not busy elsewhere
  assign admit_ok = !id_full_i && !w_full_i &&
                    (!w_busy_i || (w_sel_i == slv_aw_sel_i)) &&
                    (!lookup_busy_i || (lookup_sel_i == slv_aw_sel_i));

  // ----------------------------------------------------------------------
  // handshake control
  // ----------------------------------------------------------------------
  always_comb begin
    aw_valid       = 1'b0;
    slv_aw_ready_o = 1'b0;
    push_o         = 1'b0;
    lock_d         = lock_q;
    if (lock_q) begin
      // already pushed, keep valid up until the port takes it
      aw_valid = 1'b1;
      if (aw_ready) begin
        slv_aw_ready_o = 1'b1;
        lock_d         = 1'b0;
      end
    end else if (slv_aw_valid_i && admit_ok) begin
      aw_valid = 1'b1;
      // one push per AW, on first assertion
      push_o   = 1'b1;
      if (aw_ready) begin
        slv_aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // ----------------------------------------------------------------------
  // fan-out
  // ----------------------------------------------------------------------
  assign mst_aw_id_o   = slv_aw_id_i;
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;

  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      mst_aw_valid_o[i] = aw_valid && (slv_aw_sel_i == sel_t'(i));
    end
  end

endmodule

//--- src/w_steer.sv
// open W burst counter, W port select register and W beat demux

`timescale 1ns/10ps

module w_steer #(
  parameter int unsigned MaxTrans = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // AW admission
  input  logic                 push_i,
  input  demux_pkg::sel_t      aw_sel_i,
  // slave W
  input  demux_pkg::data_t     slv_w_data_i,
  input  logic                 slv_w_last_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  // master W
  output demux_pkg::data_t     mst_w_data_o,
  output logic                 mst_w_last_o,
  output demux_pkg::port_vec_t mst_w_valid_o,
  input  demux_pkg::port_vec_t mst_w_ready_i,
  // status for AW admission
  output logic                 w_busy_o,
  output demux_pkg::sel_t      w_sel_o,
  output logic                 w_full_o
);
  import demux_pkg::*;

  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);
  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t open_q;
  sel_t sel_q;
  sel_t w_sel;
  logic w_active;
  logic w_down;

  assign w_busy_o = (open_q != '0);
  assign w_full_o = (open_q == cnt_t'(MaxTrans));
  assign w_sel_o  = sel_q;

  // with nothing open the W beat follows the AW being admitted now
  assign w_sel    = w_busy_o ? sel_q : aw_sel_i;
  assign w_active = w_busy_o | push_i;

  // ----------------------------------------------------------------------
  // beat demux
  // ----------------------------------------------------------------------
  assign mst_w_data_o = slv_w_data_i;
  assign mst_w_last_o = slv_w_last_i;

  always_comb begin
    mst_w_valid_o = '0;
    slv_w_ready_o = 1'b0;
    if (w_active) begin
      mst_w_valid_o[w_sel] = slv_w_valid_i;
      slv_w_ready_o        = mst_w_ready_i[w_sel];
    end
  end

  // burst closes on the transfer of its last beat
  assign w_down = slv_w_valid_i & slv_w_ready_o & slv_w_last_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      open_q <= '0;
      sel_q  <= '0;
    end else begin
      if (push_i && !w_down) begin
        open_q <= open_q + cnt_t'(1);
      end else if (w_down && !push_i) begin
        open_q <= open_q - cnt_t'(1);
      end
      if (push_i) begin
        sel_q <= aw_sel_i;
      end
    end
  end

endmodule

//--- src/b_rr_arbiter.sv
// round-robin merge of the master B channels, lock-in on stall

`timescale 1ns/10ps

module b_rr_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // master B
  input  demux_pkg::id_t [demux_pkg::NumPorts-1:0]    mst_b_id_i,
  input  demux_pkg::resp_t [demux_pkg::NumPorts-1:0]  mst_b_resp_i,
  input  demux_pkg::port_vec_t                        mst_b_valid_i,
  output demux_pkg::port_vec_t                        mst_b_ready_o,
  // slave B
  output demux_pkg::id_t                              slv_b_id_o,
  output demux_pkg::resp_t                            slv_b_resp_o,
  output logic                                        slv_b_valid_o,
  input  logic                                        slv_b_ready_i,
  // slave B handshake strobe
  output logic                                        b_done_o
);
  import demux_pkg::*;

  sel_t last_q;
  sel_t lock_idx_q;
  logic lock_q;
  sel_t rr_idx;
  sel_t gnt_idx;

  // ----------------------------------------------------------------------
  // next valid port after the last grant
  // ----------------------------------------------------------------------
  always_comb begin
    sel_t cand;
    logic found;
    cand   = last_q;
    found  = 1'b0;
    rr_idx = last_q;
    // last step wraps to last_q itself
    for (int unsigned k = 1; k <= NumPorts; k++) begin
      cand = sel_t'(last_q + k);
      if (!found && mst_b_valid_i[cand]) begin
        rr_idx = cand;
        found  = 1'b1;
      end
    end
  end

  // stalled grant stays put until the slave takes it
  assign gnt_idx = lock_q ? lock_idx_q : rr_idx;

  assign slv_b_valid_o = mst_b_valid_i[gnt_idx];
  assign slv_b_id_o    = mst_b_id_i[gnt_idx];
  assign slv_b_resp_o  = mst_b_resp_i[gnt_idx];
  assign b_done_o      = slv_b_valid_o & slv_b_ready_i;

  always_comb begin
    mst_b_ready_o          = '0;
    mst_b_ready_o[gnt_idx] = b_done_o;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q     <= '0;
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else begin
      lock_q <= slv_b_valid_o & !slv_b_ready_i;
      if (slv_b_valid_o && !slv_b_ready_i) begin
        lock_idx_q <= gnt_idx;
      end
      // advance priority only on a completed transfer
      if (b_done_o) begin
        last_q <= gnt_idx;
      end
    end
  end

endmodule

//--- src/axi_write_demux.sv
// write-side AXI4 demux top, one slave port to four master ports

`timescale 1ns/10ps

module axi_write_demux #(
  parameter int unsigned MaxTrans = 8,
  parameter int unsigned LookBits = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // slave AW
  input  demux_pkg::id_t                              slv_aw_id_i,
  input  demux_pkg::addr_t                            slv_aw_addr_i,
  input  demux_pkg::len_t                             slv_aw_len_i,
  input  demux_pkg::sel_t                             slv_aw_sel_i,
  input  logic                                        slv_aw_valid_i,
  output logic                                        slv_aw_ready_o,
  // slave W
  input  demux_pkg::data_t                            slv_w_data_i,
  input  logic                                        slv_w_last_i,
  input  logic                                        slv_w_valid_i,
  output logic                                        slv_w_ready_o,
  // slave B
  output demux_pkg::id_t                              slv_b_id_o,
  output demux_pkg::resp_t                            slv_b_resp_o,
  output logic                                        slv_b_valid_o,
  input  logic                                        slv_b_ready_i,
  // master AW
  output demux_pkg::id_t                              mst_aw_id_o,
  output demux_pkg::addr_t                            mst_aw_addr_o,
  output demux_pkg::len_t                             mst_aw_len_o,
  output demux_pkg::port_vec_t                        mst_aw_valid_o,
  input  demux_pkg::port_vec_t                        mst_aw_ready_i,
  // master W
  output demux_pkg::data_t                            mst_w_data_o,
  output logic                                        mst_w_last_o,
  output demux_pkg::port_vec_t                        mst_w_valid_o,
  input  demux_pkg::port_vec_t                        mst_w_ready_i,
  // master B
  input  demux_pkg::id_t [demux_pkg::NumPorts-1:0]    mst_b_id_i,
  input  demux_pkg::resp_t [demux_pkg::NumPorts-1:0]  mst_b_resp_i,
  input  demux_pkg::port_vec_t                        mst_b_valid_i,
  output demux_pkg::port_vec_t                        mst_b_ready_o
);
  import demux_pkg::*;

  // admission strobe and status between the blocks
  logic push;
  sel_t lookup_sel;
  logic lookup_busy;
  logic id_full;
  logic w_busy;
  sel_t w_sel;
  logic w_full;
  logic b_done;

  // ----------------------------------------------------------------------
  // ID ordering, popped by the merged B
  // ----------------------------------------------------------------------
  demux_id_table #(
    .MaxTrans ( MaxTrans ),
    .LookBits ( LookBits )
  ) i_id_table (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .lookup_id_i   ( slv_aw_id_i  ),
    .lookup_sel_o  ( lookup_sel   ),
    .lookup_busy_o ( lookup_busy  ),
    .full_o        ( id_full      ),
    .push_i        ( push         ),
    .push_id_i     ( slv_aw_id_i  ),
    .push_sel_i    ( slv_aw_sel_i ),
    .pop_i         ( b_done       ),
    .pop_id_i      ( slv_b_id_o   )
  );

  // ----------------------------------------------------------------------
  // AW channel
  // ----------------------------------------------------------------------
  aw_route_ctrl i_aw_route_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_aw_id_i    ( slv_aw_id_i    ),
    .slv_aw_addr_i  ( slv_aw_addr_i  ),
    .slv_aw_len_i   ( slv_aw_len_i   ),
    .slv_aw_sel_i   ( slv_aw_sel_i   ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .mst_aw_id_o    ( mst_aw_id_o    ),
    .mst_aw_addr_o  ( mst_aw_addr_o  ),
    .mst_aw_len_o   ( mst_aw_len_o   ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .lookup_sel_i   ( lookup_sel     ),
    .lookup_busy_i  ( lookup_busy    ),
    .id_full_i      ( id_full        ),
    .w_busy_i       ( w_busy         ),
    .w_full_i       ( w_full         ),
    .w_sel_i        ( w_sel          ),
    .push_o         ( push           )
  );

  // ----------------------------------------------------------------------
  // W channel
  // ----------------------------------------------------------------------
  w_steer #(
    .MaxTrans ( MaxTrans )
  ) i_w_steer (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .push_i        ( push          ),
    .aw_sel_i      ( slv_aw_sel_i  ),
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i ),
    .w_busy_o      ( w_busy        ),
    .w_sel_o       ( w_sel         ),
    .w_full_o      ( w_full        )
  );

  // ----------------------------------------------------------------------
  // B channel
  // ----------------------------------------------------------------------
  b_rr_arbiter i_b_rr_arbiter (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i ),
    .b_done_o      ( b_done        )
  );

endmodule

//--- tb/tb_axi_write_demux.sv
// testbench for the write demux with file-driven slave traffic,
// random master back-pressure and AW, W and B checks

`timescale 1ns/10ps

module tb_axi_write_demux;
  import demux_pkg::*;

  localparam int unsigned NumTxn  = 16;
  localparam int unsigned NumCols = 6;
  localparam int unsigned Timeout = 2000;

  logic clk;
  logic rst_n;
  // slave side
  id_t   slv_aw_id;
  addr_t slv_aw_addr;
  len_t  slv_aw_len;
  sel_t  slv_aw_sel;
  logic  slv_aw_valid;
  logic  slv_aw_ready;
  data_t slv_w_data;
  logic  slv_w_last;
  logic  slv_w_valid;
  logic  slv_w_ready;
  id_t   slv_b_id;
  resp_t slv_b_resp;
  logic  slv_b_valid;
  logic  slv_b_ready;
  // master side
  id_t       mst_aw_id;
  addr_t     mst_aw_addr;
  len_t      mst_aw_len;
  port_vec_t mst_aw_valid;
  port_vec_t mst_aw_ready;
  data_t     mst_w_data;
  logic      mst_w_last;
  port_vec_t mst_w_valid;
  port_vec_t mst_w_ready;
  id_t   [NumPorts-1:0] mst_b_id;
  resp_t [NumPorts-1:0] mst_b_resp;
  port_vec_t mst_b_valid;
  port_vec_t mst_b_ready;

  // stimulus table with NumCols words per transaction
  logic [31:0] stim [NumTxn*NumCols];
  logic [31:0] lfsr;
  // expected W beats in slave order
  data_t exp_w_data [$];
  logic  exp_w_last [$];
  sel_t  exp_w_port [$];
  // B responses still owed to the slave
  id_t   pend_id [$];
  resp_t pend_resp [$];
  int unsigned out_cnt [2**IdWidth][NumPorts];
  int unsigned aw_idx;
  int unsigned b_count;
  logic aw_wait;
  sel_t aw_wait_port;
  // master port model state
  id_t aw_ids [NumPorts][$];
  id_t b_ids [NumPorts][$];
  int unsigned w_done [NumPorts];
  logic [NumPorts-1:0] b_taken;

  axi_write_demux #(
    .MaxTrans ( 8 ),
    .LookBits ( 2 )
  ) i_axi_write_demux (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .slv_aw_id_i    ( slv_aw_id    ),
    .slv_aw_addr_i  ( slv_aw_addr  ),
    .slv_aw_len_i   ( slv_aw_len   ),
    .slv_aw_sel_i   ( slv_aw_sel   ),
    .slv_aw_valid_i ( slv_aw_valid ),
    .slv_aw_ready_o ( slv_aw_ready ),
    .slv_w_data_i   ( slv_w_data   ),
    .slv_w_last_i   ( slv_w_last   ),
    .slv_w_valid_i  ( slv_w_valid  ),
    .slv_w_ready_o  ( slv_w_ready  ),
    .slv_b_id_o     ( slv_b_id     ),
    .slv_b_resp_o   ( slv_b_resp   ),
    .slv_b_valid_o  ( slv_b_valid  ),
    .slv_b_ready_i  ( slv_b_ready  ),
    .mst_aw_id_o    ( mst_aw_id    ),
    .mst_aw_addr_o  ( mst_aw_addr  ),
    .mst_aw_len_o   ( mst_aw_len   ),
    .mst_aw_valid_o ( mst_aw_valid ),
    .mst_aw_ready_i ( mst_aw_ready ),
    .mst_w_data_o   ( mst_w_data   ),
    .mst_w_last_o   ( mst_w_last   ),
    .mst_w_valid_o  ( mst_w_valid  ),
    .mst_w_ready_i  ( mst_w_ready  ),
    .mst_b_id_i     ( mst_b_id     ),
    .mst_b_resp_i   ( mst_b_resp   ),
    .mst_b_valid_i  ( mst_b_valid  ),
    .mst_b_ready_o  ( mst_b_ready  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // galois step with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  // a burst may answer once both its AW and its last W beat are in
  task automatic release_b(input sel_t p);
    while (aw_ids[p].size() > 0 && w_done[p] > 0) begin
      b_ids[p].push_back(aw_ids[p].pop_front());
      w_done[p]--;
    end
  endtask

  // called 1 ns after an edge and returns 1 ns after the transfer edge
  task automatic await_slave_ready(input logic is_w);
    int unsigned cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = is_w ? slv_w_ready : slv_aw_ready;
      @(posedge clk);
      #1;
      cycles++;
      if (!done && cycles > Timeout) fail_run("timeout waiting for a slave ready");
    end
  endtask

  task automatic send_txn(input int unsigned i);
    int unsigned base;
    int unsigned beats;
    base  = i * NumCols;
    beats = int'(stim[base+3][7:0]) + 1;
    slv_aw_id    = id_t'(stim[base]);
    slv_aw_sel   = sel_t'(stim[base+1]);
    slv_aw_addr  = stim[base+2];
    slv_aw_len   = len_t'(stim[base+3]);
    slv_aw_valid = 1'b1;
    await_slave_ready(1'b0);
    slv_aw_valid = 1'b0;
    for (int unsigned k = 0; k < beats; k++) begin
      slv_w_data  = stim[base+4] + k;
      slv_w_last  = (k == beats - 1);
      slv_w_valid = 1'b1;
      await_slave_ready(1'b1);
    end
    slv_w_valid = 1'b0;
    slv_w_last  = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // monitors sampled at the falling edge where all signals are settled
  // ----------------------------------------------------------------------
  task automatic check_aw();
    int unsigned base;
    sel_t port;
    if (aw_wait) begin
      assert (mst_aw_valid[aw_wait_port])
        else fail_run($sformatf("AW valid on port %0d dropped before ready", aw_wait_port));
    end
    aw_wait = 1'b0;
    if (mst_aw_valid != '0) begin
      assert ($onehot(mst_aw_valid)) else fail_run("AW valid raised on several master ports");
      assert (aw_idx < NumTxn) else fail_run("AW seen on a master port with no transaction left");
      base = aw_idx * NumCols;
      port = sel_t'(stim[base+1]);
      assert (mst_aw_valid[port]) else fail_run($sformatf(
        "[ERROR] mst_aw_valid_o: got 0x%h, expected 0x%h", mst_aw_valid, 4'b0001 << port));
      assert (mst_aw_id == id_t'(stim[base])) else fail_run($sformatf(
        "[ERROR] mst_aw_id_o: got 0x%h, expected 0x%h", mst_aw_id, id_t'(stim[base])));
      assert (mst_aw_addr == stim[base+2]) else fail_run($sformatf(
        "[ERROR] mst_aw_addr_o: got 0x%h, expected 0x%h", mst_aw_addr, stim[base+2]));
      assert (mst_aw_len == len_t'(stim[base+3])) else fail_run($sformatf(
        "[ERROR] mst_aw_len_o: got 0x%h, expected 0x%h", mst_aw_len, len_t'(stim[base+3])));
      // ID must have nothing open on any other port
      for (int q = 0; q < NumPorts; q++) begin
        assert (sel_t'(q) == port || out_cnt[mst_aw_id][q] == 0) else fail_run($sformatf(
          "AW with ID 0x%h went out while still open on port %0d", mst_aw_id, q));
      end
      if (mst_aw_ready[port]) begin
        aw_ids[port].push_back(mst_aw_id);
        out_cnt[mst_aw_id][port]++;
        pend_id.push_back(mst_aw_id);
        pend_resp.push_back(resp_t'(stim[base+5]));
        aw_idx++;
        release_b(port);
      end else begin
        aw_wait      = 1'b1;
        aw_wait_port = port;
      end
    end
  endtask

  task automatic check_w();
    sel_t port;
    port = '0;
    if (mst_w_valid != '0) begin
      assert ($onehot(mst_w_valid)) else fail_run("W valid raised on several master ports");
      assert (exp_w_data.size() > 0) else fail_run("W beat seen with no beat left to send");
      for (int q = 0; q < NumPorts; q++) begin
        if (mst_w_valid[q]) port = sel_t'(q);
      end
      assert (port == exp_w_port[0]) else fail_run($sformatf(
        "[ERROR] mst_w_valid_o: got 0x%h, expected 0x%h", mst_w_valid, 4'b0001 << exp_w_port[0]));
      if (mst_w_ready[port]) begin
        assert (mst_w_data == exp_w_data[0]) else fail_run($sformatf(
          "[ERROR] mst_w_data_o: got 0x%h, expected 0x%h", mst_w_data, exp_w_data[0]));
        assert (mst_w_last == exp_w_last[0]) else fail_run($sformatf(
          "[ERROR] mst_w_last_o: got 0x%h, expected 0x%h", mst_w_last, exp_w_last[0]));
        void'(exp_w_data.pop_front());
        void'(exp_w_last.pop_front());
        void'(exp_w_port.pop_front());
        if (mst_w_last) begin
          w_done[port]++;
          release_b(port);
        end
      end
    end
  endtask

  task automatic check_b();
    int idx;
    idx = -1;
    if (slv_b_valid && slv_b_ready) begin
      // oldest open transaction with this ID
      for (int k = 0; k < pend_id.size(); k++) begin
        if (idx < 0 && pend_id[k] == slv_b_id) idx = k;
      end
      assert (idx >= 0) else fail_run($sformatf(
        "slave B with ID 0x%h matches no open transaction", slv_b_id));
      assert (slv_b_resp == pend_resp[idx]) else fail_run($sformatf(
        "[ERROR] slv_b_resp_o: got 0x%h, expected 0x%h", slv_b_resp, pend_resp[idx]));
      out_cnt[slv_b_id][slv_b_resp]--;
      pend_id.delete(idx);
      pend_resp.delete(idx);
      b_count++;
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (mst_b_valid[p] && mst_b_ready[p]) b_taken[p] = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check_aw();
      check_w();
      check_b();
    end
  end

  // ----------------------------------------------------------------------
  // master port models and slave B ready
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    logic b;
    #1;
    for (int p = 0; p < NumPorts; p++) begin
      draw_bit(b);
      mst_aw_ready[p] = b;
      draw_bit(b);
      mst_w_ready[p] = b;
      if (b_taken[p]) begin
        mst_b_valid[p] = 1'b0;
        b_taken[p]     = 1'b0;
      end
      // response code is the port index
      if (!mst_b_valid[p] && b_ids[p].size() > 0) begin
        draw_bit(b);
        if (b) begin
          mst_b_id[p]    = b_ids[p].pop_front();
          mst_b_resp[p]  = resp_t'(p);
          mst_b_valid[p] = 1'b1;
        end
      end
    end
    draw_bit(b);
    slv_b_ready = b;
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int unsigned cycles;
    int unsigned base;
    rst_n        = 1'b0;
    slv_aw_id    = '0;
    slv_aw_addr  = '0;
    slv_aw_len   = '0;
    slv_aw_sel   = '0;
    slv_aw_valid = 1'b0;
    slv_w_data   = '0;
    slv_w_last   = 1'b0;
    slv_w_valid  = 1'b0;
    slv_b_ready  = 1'b0;
    mst_aw_ready = '0;
    mst_w_ready  = '0;
    mst_b_id     = '0;
    mst_b_resp   = '0;
    mst_b_valid  = '0;
    lfsr         = 32'h72b0_7203;
    aw_idx       = 0;
    b_count      = 0;
    aw_wait      = 1'b0;
    aw_wait_port = '0;
    b_taken      = '0;
    for (int p = 0; p < NumPorts; p++) begin
      w_done[p] = 0;
      for (int i = 0; i < 2**IdWidth; i++) begin
        out_cnt[i][p] = 0;
      end
    end
    $readmemh("tb/write_demux_input.txt", stim);
    assert (!$isunknown(stim[NumTxn*NumCols-1]))
      else fail_run("stimulus file tb/write_demux_input.txt could not be read");
    // expected W stream with data counting up from the first word
    for (int unsigned i = 0; i < NumTxn; i++) begin
      base = i * NumCols;
      for (int unsigned k = 0; k <= int'(stim[base+3][7:0]); k++) begin
        exp_w_data.push_back(stim[base+4] + k);
        exp_w_last.push_back(k == int'(stim[base+3][7:0]));
        exp_w_port.push_back(sel_t'(stim[base+1]));
      end
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int unsigned i = 0; i < NumTxn; i++) begin
      send_txn(i);
    end
    cycles = 0;
    while (b_count < NumTxn) begin
      @(posedge clk);
      cycles++;
      if (cycles > Timeout) fail_run("timeout waiting for the slave B responses");
    end
    // a few idle cycles to catch stray responses
    repeat (10) @(negedge clk);
    assert (!slv_b_valid) begin
      $display("Simulation passed");
    end else begin
      fail_run("slave B valid still raised with no transaction open");
    end
    $finish;
  end

endmodule

//--- build.f
src/demux_pkg.sv
src/demux_id_table.sv
src/aw_route_ctrl.sv
src/w_steer.sv
src/b_rr_arbiter.sv
src/axi_write_demux.sv
tb/tb_axi_write_demux.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_axi_write_demux
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/write_demux_input.txt
// columns in hex: id, port select, address, burst length minus one, first data word, B response
// the B response is the index of the selected master port
1 0 00001000 03 a0000000 0
1 0 00001040 00 a1000000 0
1 2 00002000 01 a2000000 2
2 1 00003000 07 b0000000 1
3 3 00004000 00 b1000000 3
2 3 00004100 02 b2000000 3
4 0 00005000 01 c0000000 0
7 1 00006000 03 c1000000 1
4 0 00005080 00 c2000000 0
7 2 00007000 01 c3000000 2
0 3 00008000 05 d0000000 3
0 1 00009000 00 d1000000 1
5 2 0000a000 02 d2000000 2
6 2 0000a100 01 d3000000 2
5 0 0000b000 03 e0000000 0
f 1 0000c000 00 e1000000 1
